//--- hdl/plic_pkg.sv
// PLIC shared definitions
// Sizes, register address map, decode enums and the address decoder
package plic_pkg;

  // --------------------
  // Sizes
  // Source 0 is reserved, real sources are 1..NUM_SOURCES
  localparam int NUM_SOURCES     = 7;
  localparam int SOURCE_ID_WIDTH = 3;
  // Priority 0 never interrupts
  localparam int PRIORITY_WIDTH  = 3;
  localparam int THRESHOLD_WIDTH = 32;

  // --------------------
  // Word address map (byte address >> 2)
  localparam logic [21:0] PRIO_BASE      = 22'h000000;
  localparam logic [21:0] PENDING_ADDR   = 22'h000400;
  localparam logic [21:0] ENABLE_ADDR    = 22'h000800;
  localparam logic [21:0] THRESHOLD_ADDR = 22'h080000;
  localparam logic [21:0] CLAIM_ADDR     = 22'h080001;

  // Register window selected by a word address
  typedef enum logic [2:0] {
    REG_NONE,
    REG_PRIORITY,
    REG_PENDING,
    REG_ENABLE,
    REG_THRESHOLD,
    REG_CLAIM
  } plic_reg_e;

  // Gateway FSM states
  typedef enum logic [1:0] {
    GW_IDLE,
    GW_REQUESTED,
    GW_IN_SERVICE
  } gw_state_e;

  // Priority window covers word addresses 0..7, one word per source
  function automatic plic_reg_e plic_decode(input logic [21:0] addr);
    plic_reg_e reg_sel;
    if (addr[21:3] == PRIO_BASE[21:3]) begin
      reg_sel = REG_PRIORITY;
    end else if (addr == PENDING_ADDR) begin
      reg_sel = REG_PENDING;
    end else if (addr == ENABLE_ADDR) begin
      reg_sel = REG_ENABLE;
    end else if (addr == THRESHOLD_ADDR) begin
      reg_sel = REG_THRESHOLD;
    end else if (addr == CLAIM_ADDR) begin
      reg_sel = REG_CLAIM;
    end else begin
      reg_sel = REG_NONE;
    end
    return reg_sel;
  endfunction

endpackage

//--- hdl/plic_gateway.sv
// PLIC level-sensitive interrupt gateway
// Turns a source level into one pending pulse, then blocks until completion
`timescale 1ns/1ps

module plic_gateway
  import plic_pkg::*;
#(
  parameter int SRC_ID = 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       src_i,
  input  logic                       complete_vld_i,
  input  logic [SOURCE_ID_WIDTH-1:0] complete_id_i,
  output logic                       pending_o
);

  gw_state_e state_q;
  gw_state_e state_d;
  logic      complete_hit;

  // Completion addressed to this source only
  assign complete_hit = complete_vld_i &&
                        (complete_id_i == SOURCE_ID_WIDTH'(SRC_ID));

  // --------------------
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      GW_IDLE: begin
        // Level seen, forward one request
        if (src_i) begin
          state_d = GW_REQUESTED;
        end
      end
      // Pulse has been sent, block further requests
      GW_REQUESTED: state_d = GW_IN_SERVICE;
      GW_IN_SERVICE: begin
        // Wait for software to write our ID to complete
        if (complete_hit) begin
          state_d = GW_IDLE;
        end
      end
      default: state_d = GW_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= GW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // One-cycle pulse, only in the cycle after leaving idle
  assign pending_o = (state_q == GW_REQUESTED);

  // A request is a single event, never a held level
  a_pending_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pending_o |=> !pending_o)
    else $error("gateway %0d pending held for two cycles", SRC_ID);

endmodule

//--- hdl/plic_wb_slave.sv
// PLIC Wishbone-lite slave front end
// One-cycle core strobes per access, registered read data, one-cycle ack
`timescale 1ns/1ps

module plic_wb_slave
  import plic_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // Wishbone-lite bus
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [23:0] wb_addr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_wdata_i,
  output logic [31:0] wb_rdata_o,
  output logic        wb_ack_o,
  // Core side
  output logic        rd_stb_o,
  output logic        wr_stb_o,
  output logic [21:0] addr_o,
  output logic [31:0] wdata_o,
  output logic [3:0]  sel_o,
  input  logic [31:0] rd_data_i
);

  logic        ack_q;
  logic        access;
  logic [31:0] rdata_q;

  // Strobe in the first cycle of stb only since ack blocks the repeat
  assign access   = wb_cyc_i && wb_stb_i && !ack_q;
  assign rd_stb_o = access && !wb_we_i;
  assign wr_stb_o = access && wb_we_i;

  // Word address with the byte offset bits dropped
  assign addr_o  = wb_addr_i[23:2];
  assign wdata_o = wb_wdata_i;
  assign sel_o   = wb_sel_i;

  // --------------------
  // Ack and read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Capture in the strobe cycle so a claim returns the pre-clear winner
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rd_stb_o) begin
      rdata_q <= rd_data_i;
    end
  end

  assign wb_ack_o   = ack_q;
  assign wb_rdata_o = rdata_q;

  // Every access gets exactly one ack cycle
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_o |=> !wb_ack_o)
    else $error("wishbone ack held for two cycles");

endmodule

//--- hdl/plic_core.sv
// PLIC core for one hart context
// Priority, pending, enable and threshold registers, arbitration, claim/complete
`timescale 1ns/1ps

module plic_core
  import plic_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Register access strobes from the bus slave
  input  logic                       rd_stb_i,
  input  logic                       wr_stb_i,
  input  logic [21:0]                addr_i,
  input  logic [31:0]                wdata_i,
  input  logic [3:0]                 sel_i,
  output logic [31:0]                rd_data_o,
  // Gateway interface
  input  logic [NUM_SOURCES:1]       gw_pending_i,
  output logic                       complete_vld_o,
  output logic [SOURCE_ID_WIDTH-1:0] complete_id_o,
  // Interrupt to the hart
  output logic                       irq_o
);

  plic_reg_e                  reg_sel;
  logic [PRIORITY_WIDTH-1:0]  prio_q [1:NUM_SOURCES];
  logic [NUM_SOURCES:1]       ip_q;
  logic [NUM_SOURCES:1]       en_q;
  logic [THRESHOLD_WIDTH-1:0] thr_q;
  logic                       claim;
  logic [NUM_SOURCES:1]       eligible;
  logic [PRIORITY_WIDTH-1:0]  chain_prio [0:NUM_SOURCES];
  logic [SOURCE_ID_WIDTH-1:0] chain_id   [0:NUM_SOURCES];
  logic [PRIORITY_WIDTH-1:0]  max_prio;
  logic [SOURCE_ID_WIDTH-1:0] max_id;

  assign reg_sel = plic_decode(addr_i);

  // --------------------
  // Priority registers
  // Source n sits at word n, word 0 is source 0 and is not stored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i <= NUM_SOURCES; i++) begin
        prio_q[i] <= '0;
      end
    end else if (wr_stb_i && (reg_sel == REG_PRIORITY) && sel_i[0]) begin
      for (int i = 1; i <= NUM_SOURCES; i++) begin
        if (addr_i[2:0] == SOURCE_ID_WIDTH'(i)) begin
          prio_q[i] <= wdata_i[PRIORITY_WIDTH-1:0];
        end
      end
    end
  end

  // --------------------
  // Claim and complete
  // Both live at the same word, read claims and write completes
  assign claim          = rd_stb_i && (reg_sel == REG_CLAIM);
  assign complete_vld_o = wr_stb_i && (reg_sel == REG_CLAIM);
  assign complete_id_o  = wdata_i[SOURCE_ID_WIDTH-1:0];

  // --------------------
  // Pending bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ip_q <= '0;
    end else begin
      for (int i = 1; i <= NUM_SOURCES; i++) begin
        // A new request wins over a same-cycle claim
        if (gw_pending_i[i]) begin
          ip_q[i] <= 1'b1;
        end else if (claim && (max_id == SOURCE_ID_WIDTH'(i))) begin
          ip_q[i] <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // Enable bits
  // All seven enables fit in byte lane 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= '0;
    end else if (wr_stb_i && (reg_sel == REG_ENABLE) && sel_i[0]) begin
      en_q <= wdata_i[NUM_SOURCES:1];
    end
  end

  // --------------------
  // Threshold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thr_q <= '0;
    end else if (wr_stb_i && (reg_sel == REG_THRESHOLD)) begin
      // Per byte lane update
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          thr_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // --------------------
  // Arbitration chain
  // Only enabled and pending sources compete
  assign eligible = ip_q & en_q;

  // Stage 0 is the empty source 0 with priority zero
  assign chain_prio[0] = '0;
  assign chain_id[0]   = '0;

  for (genvar n = 1; n <= NUM_SOURCES; n++) begin : g_chain
    logic [PRIORITY_WIDTH-1:0] cand_prio;
    logic                      take;

    assign cand_prio = eligible[n] ? prio_q[n] : '0;
    // Strict compare keeps the earlier, lower ID on a tie
    assign take          = cand_prio > chain_prio[n-1];
    assign chain_prio[n] = take ? cand_prio : chain_prio[n-1];
    assign chain_id[n]   = take ? SOURCE_ID_WIDTH'(n) : chain_id[n-1];
  end

  assign max_prio = chain_prio[NUM_SOURCES];
  assign max_id   = chain_id[NUM_SOURCES];

  // Interrupt when the best priority exceeds the threshold
  assign irq_o = THRESHOLD_WIDTH'(max_prio) > thr_q;

  // --------------------
  // Read mux
  always_comb begin
    rd_data_o = 32'd0;
    case (reg_sel)
      REG_PRIORITY: begin
        for (int i = 1; i <= NUM_SOURCES; i++) begin
          if (addr_i[2:0] == SOURCE_ID_WIDTH'(i)) begin
            rd_data_o = 32'(prio_q[i]);
          end
        end
      end
      // Bit 0 stands for source 0, always clear
      REG_PENDING:   rd_data_o = 32'({ip_q, 1'b0});
      REG_ENABLE:    rd_data_o = 32'({en_q, 1'b0});
      REG_THRESHOLD: rd_data_o = thr_q;
      REG_CLAIM:     rd_data_o = 32'(max_id);
      default:       rd_data_o = 32'd0;
    endcase
  end

  // Interrupt must always point at a real source to claim
  a_irq_has_id: assert property (@(posedge clk) disable iff (!rst_n)
    irq_o |-> (max_id != '0))
    else $error("irq raised with no claimable source");

endmodule

//--- hdl/plic_top.sv
// PLIC top level
// Wishbone-lite slave, register core and one gateway per interrupt source
`timescale 1ns/1ps

module plic_top
  import plic_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Wishbone-lite bus
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [23:0]          wb_addr_i,
  input  logic [3:0]           wb_sel_i,
  input  logic [31:0]          wb_wdata_i,
  output logic [31:0]          wb_rdata_o,
  output logic                 wb_ack_o,
  // Interrupt sources and hart interrupt
  input  logic [NUM_SOURCES:1] src_i,
  output logic                 irq_o
);

  logic                       rd_stb;
  logic                       wr_stb;
  logic [21:0]                word_addr;
  logic [31:0]                wdata;
  logic [3:0]                 sel;
  logic [31:0]                rd_data;
  logic [NUM_SOURCES:1]       gw_pending;
  logic                       complete_vld;
  logic [SOURCE_ID_WIDTH-1:0] complete_id;

  // Bus front end
  plic_wb_slave u_wb_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_addr_i  (wb_addr_i),
    .wb_sel_i   (wb_sel_i),
    .wb_wdata_i (wb_wdata_i),
    .wb_rdata_o (wb_rdata_o),
    .wb_ack_o   (wb_ack_o),
    .rd_stb_o   (rd_stb),
    .wr_stb_o   (wr_stb),
    .addr_o     (word_addr),
    .wdata_o    (wdata),
    .sel_o      (sel),
    .rd_data_i  (rd_data)
  );

  plic_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_stb_i       (rd_stb),
    .wr_stb_i       (wr_stb),
    .addr_i         (word_addr),
    .wdata_i        (wdata),
    .sel_i          (sel),
    .rd_data_o      (rd_data),
    .gw_pending_i   (gw_pending),
    .complete_vld_o (complete_vld),
    .complete_id_o  (complete_id),
    .irq_o          (irq_o)
  );

  // One gateway per source, ID equals the source number
  for (genvar s = 1; s <= NUM_SOURCES; s++) begin : g_gw
    plic_gateway #(
      .SRC_ID (s)
    ) u_gw (
      .clk            (clk),
      .rst_n          (rst_n),
      .src_i          (src_i[s]),
      .complete_vld_i (complete_vld),
      .complete_id_i  (complete_id),
      .pending_o      (gw_pending[s])
    );
  end

endmodule

//--- testbench/plic_tb.sv
// PLIC testbench
// Directed stimulus table, then LCG rounds checked against a reference model
`timescale 1ns/1ps

module plic_tb
  import plic_pkg::*;
();

  localparam int ROUNDS = 50;
  // Byte addresses of the register windows
  localparam logic [23:0] PEND_A  = {PENDING_ADDR, 2'b00};
  localparam logic [23:0] EN_A    = {ENABLE_ADDR, 2'b00};
  localparam logic [23:0] THR_A   = {THRESHOLD_ADDR, 2'b00};
  localparam logic [23:0] CLAIM_A = {CLAIM_ADDR, 2'b00};
  localparam logic [23:0] NONE_A  = 24'h003000;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_SRC, OP_IRQ} op_e;
  typedef struct packed {
    op_e         op;
    logic [23:0] addr;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [23:0]          wb_addr;
  logic [3:0]           wb_sel;
  logic [31:0]          wb_wdata;
  logic [31:0]          wb_rdata;
  logic                 wb_ack;
  logic [NUM_SOURCES:1] src;
  logic                 irq;
  step_t                steps[$];
  logic [31:0]          lcg_state;
  int                   cycles = 0;
  int                   limit;

  plic_top plic_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_addr_i  (wb_addr),
    .wb_sel_i   (wb_sel),
    .wb_wdata_i (wb_wdata),
    .wb_rdata_o (wb_rdata),
    .wb_ack_o   (wb_ack),
    .src_i      (src),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display(">>> FAIL");
      $fatal(1, "run timed out");
    end
  end

  // --------------------
  // Helpers
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [23:0] prio_addr(input int n);
    return {PRIO_BASE, 2'b00} + 24'(4 * n);
  endfunction

  // One Wishbone access held until ack with data sampled mid-cycle
  task automatic bus_access(input logic we, input logic [23:0] addr, input logic [3:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_addr  <= addr;
    wb_sel   <= sel;
    wb_wdata <= wdata;
    do @(negedge clk); while (!wb_ack);
    rdata = wb_rdata;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic wb_write(input logic [23:0] addr, input logic [3:0] sel, input logic [31:0] d);
    logic [31:0] unused;
    bus_access(1'b1, addr, sel, d, unused);
  endtask

  task automatic wb_read(input logic [23:0] addr, output logic [31:0] d);
    bus_access(1'b0, addr, 4'hF, 32'd0, d);
  endtask

  // Reads until the value matches or the retries run out
  task automatic poll_read(input logic [23:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    got = ~exp;
    for (int i = 0; i < 20 && got !== exp; i++) begin
      wb_read(addr, got);
    end
    check_eq(got, exp, $sformatf("poll of 0x%06h", addr));
  endtask

  task automatic wait_irq(input logic exp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (irq !== exp && n < 20);
    check_eq(32'(irq), 32'(exp), "irq_o level");
  endtask

  task automatic set_source(input logic [NUM_SOURCES:1] levels);
    @(posedge clk);
    src <= levels;
  endtask

  task automatic add_step(input op_e op, input logic [23:0] addr, input logic [3:0] sel,
                          input logic [31:0] data, input logic [31:0] exp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.sel  = sel;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] got;
    case (s.op)
      OP_WRITE: wb_write(s.addr, s.sel, s.data);
      OP_READ: begin
        wb_read(s.addr, got);
        check_eq(got, s.exp, $sformatf("read of 0x%06h", s.addr));
      end
      OP_POLL: poll_read(s.addr, s.exp);
      OP_SRC:  set_source(s.data[NUM_SOURCES:1]);
      OP_IRQ:  wait_irq(s.exp[0]);
      default: begin
        $display("The stimulus table holds an unknown step opcode %0d", s.op);
        $display(">>> FAIL");
        $fatal(1, "bad stimulus table");
      end
    endcase
  endtask

  // --------------------
  // Directed table
  task automatic build_table();
    // Register access
    add_step(OP_WRITE, prio_addr(1), 4'hF, 32'd3, 32'd0);
    add_step(OP_WRITE, prio_addr(2), 4'hF, 32'd5, 32'd0);
    add_step(OP_WRITE, prio_addr(3), 4'hF, 32'd5, 32'd0);
    add_step(OP_WRITE, prio_addr(7), 4'hF, 32'hFF, 32'd0);
    add_step(OP_READ,  prio_addr(2), 4'hF, 32'd0, 32'd5);
    add_step(OP_READ,  prio_addr(7), 4'hF, 32'd0, 32'd7);
    add_step(OP_READ,  prio_addr(0), 4'hF, 32'd0, 32'd0);
    add_step(OP_WRITE, EN_A,   4'hF, 32'h0A, 32'd0);
    add_step(OP_READ,  EN_A,   4'hF, 32'd0, 32'h0A);
    add_step(OP_WRITE, THR_A,  4'hF, 32'h12345678, 32'd0);
    add_step(OP_WRITE, THR_A,  4'h2, 32'hAABBCCDD, 32'd0);
    add_step(OP_READ,  THR_A,  4'hF, 32'd0, 32'h1234CC78);
    add_step(OP_WRITE, THR_A,  4'hF, 32'd0, 32'd0);
    add_step(OP_READ,  NONE_A, 4'hF, 32'd0, 32'd0);
    add_step(OP_WRITE, EN_A,   4'hF, 32'd0, 32'd0);
    // Pending and irq with source 3 at priority 5
    add_step(OP_SRC,   24'd0,  4'h0, 32'h08, 32'd0);
    add_step(OP_POLL,  PEND_A, 4'hF, 32'd0, 32'h08);
    add_step(OP_IRQ,   24'd0,  4'h0, 32'd0, 32'd0);
    add_step(OP_WRITE, EN_A,   4'hF, 32'h08, 32'd0);
    add_step(OP_IRQ,   24'd0,  4'h0, 32'd0, 32'd1);
    add_step(OP_WRITE, THR_A,  4'hF, 32'd5, 32'd0);
    add_step(OP_IRQ,   24'd0,  4'h0, 32'd0, 32'd0);
    add_step(OP_WRITE, THR_A,  4'hF, 32'd4, 32'd0);
    add_step(OP_IRQ,   24'd0,  4'h0, 32'd0, 32'd1);
    // Claim with a priority tie between sources 2 and 3
    add_step(OP_SRC,   24'd0,   4'h0, 32'h0C, 32'd0);
    add_step(OP_WRITE, EN_A,    4'hF, 32'h0C, 32'd0);
    add_step(OP_POLL,  PEND_A,  4'hF, 32'd0, 32'h0C);
    add_step(OP_READ,  CLAIM_A, 4'hF, 32'd0, 32'd2);
    add_step(OP_READ,  PEND_A,  4'hF, 32'd0, 32'h08);
    add_step(OP_READ,  CLAIM_A, 4'hF, 32'd0, 32'd3);
    add_step(OP_READ,  CLAIM_A, 4'hF, 32'd0, 32'd0);
    add_step(OP_IRQ,   24'd0,   4'h0, 32'd0, 32'd0);
    // Gateways stay blocked until their own ID completes
    add_step(OP_WRITE, CLAIM_A, 4'hF, 32'd5, 32'd0);
    add_step(OP_READ,  PEND_A,  4'hF, 32'd0, 32'd0);
    add_step(OP_WRITE, CLAIM_A, 4'hF, 32'd2, 32'd0);
    add_step(OP_POLL,  PEND_A,  4'hF, 32'd0, 32'h04);
    add_step(OP_WRITE, CLAIM_A, 4'hF, 32'd3, 32'd0);
    add_step(OP_POLL,  PEND_A,  4'hF, 32'd0, 32'h0C);
    add_step(OP_SRC,   24'd0,   4'h0, 32'h00, 32'd0);
    add_step(OP_READ,  CLAIM_A, 4'hF, 32'd0, 32'd2);
    add_step(OP_READ,  CLAIM_A, 4'hF, 32'd0, 32'd3);
    add_step(OP_WRITE, CLAIM_A, 4'hF, 32'd2, 32'd0);
    add_step(OP_WRITE, CLAIM_A, 4'hF, 32'd3, 32'd0);
    add_step(OP_READ,  PEND_A,  4'hF, 32'd0, 32'd0);
    add_step(OP_IRQ,   24'd0,   4'h0, 32'd0, 32'd0);
  endtask

  // --------------------
  // Random round with reference model
  task automatic random_round(input int r);
    logic [PRIORITY_WIDTH-1:0] prio [1:NUM_SOURCES];
    logic [PRIORITY_WIDTH-1:0] best_p;
    logic [NUM_SOURCES:1]      en;
    logic [NUM_SOURCES:1]      lev;
    logic [31:0]               thr;
    logic [31:0]               got;
    int                        best;
    best   = 0;
    best_p = '0;
    for (int n = 1; n <= NUM_SOURCES; n++) begin
      prio[n] = PRIORITY_WIDTH'(lcg_next());
      wb_write(prio_addr(n), 4'hF, 32'(prio[n]));
    end
    en  = NUM_SOURCES'(lcg_next());
    thr = lcg_next() % 6;
    lev = NUM_SOURCES'(lcg_next());
    wb_write(EN_A, 4'hF, 32'({en, 1'b0}));
    wb_write(THR_A, 4'hF, thr);
    // Highest priority wins and the lowest ID takes a tie
    for (int n = 1; n <= NUM_SOURCES; n++) begin
      if (en[n] && lev[n] && prio[n] > best_p) begin
        best   = n;
        best_p = prio[n];
      end
    end
    set_source(lev);
    poll_read(PEND_A, 32'({lev, 1'b0}));
    wait_irq(32'(best_p) > thr);
    wb_read(CLAIM_A, got);
    check_eq(got, 32'(best), $sformatf("round %0d claim", r));
    // Drain the rest in ID order with equal priorities and complete them all
    set_source('0);
    for (int n = 1; n <= NUM_SOURCES; n++) begin
      wb_write(prio_addr(n), 4'hF, 32'd1);
    end
    wb_write(EN_A, 4'hF, 32'hFE);
    for (int n = 1; n <= NUM_SOURCES; n++) begin
      if (lev[n] && n != best) begin
        wb_read(CLAIM_A, got);
        check_eq(got, 32'(n), $sformatf("round %0d drain claim", r));
      end
    end
    wb_read(CLAIM_A, got);
    check_eq(got, 32'd0, $sformatf("round %0d empty claim", r));
    for (int n = 1; n <= NUM_SOURCES; n++) begin
      if (lev[n]) begin
        wb_write(CLAIM_A, 4'hF, 32'(n));
      end
    end
    wb_read(PEND_A, got);
    check_eq(got, 32'd0, $sformatf("round %0d pending after completion", r));
  endtask

  initial begin
    lcg_state = 32'd49180;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_addr   = '0;
    wb_sel    = '0;
    wb_wdata  = '0;
    src       = '0;
    build_table();
    limit = steps.size() * 40 + ROUNDS * 160 + 20;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    for (int r = 0; r < ROUNDS; r++) begin
      random_round(r);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- flist.f
hdl/plic_pkg.sv
hdl/plic_gateway.sv
hdl/plic_wb_slave.sv
hdl/plic_core.sv
hdl/plic_top.sv
testbench/plic_tb.sv

//--- Makefile
SIM     := verilator
TOP     := plic_tb
FLIST   := flist.f
VFLAGS  := --binary --timing --assert
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := run.log
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
